/* rtl/hbus_phy_ctrl.sv */
`timescale 1ns/100ps

module hbus_phy_ctrl (
  input  logic                 wb_clk,
  input  logic                 wb_rst,
  output hbus_pkg::hbus_addr_t hbus_adr_o,
  input  hbus_pkg::hbus_data_t hbus_dat_i,
  output hbus_pkg::hbus_data_t hbus_dat_o,
  output logic                 hbus_rrq_o,
  output logic                 hbus_wrq_o,
  input  logic                 hbus_ready_i,
  input  logic                 hbus_valid_i,
  input  logic                 hbus_busy_i,
  output logic                 rsp_valid_o,
  output hbus_pkg::wb_data_t   rsp_data_o,
  hbus_req_if.slave            dn_req
);

  hbus_pkg::phy_state_e state_q;
  logic                 pend_q;  // request latched, waiting for device
  logic                 beat_q;  // 0 low half, 1 high half
  logic                 we_q;
  hbus_pkg::wb_addr_t   adr_q;
  hbus_pkg::wb_data_t   wdata_q;
  hbus_pkg::wb_data_t   rdata_q;

  assign hbus_wrq_o = state_q == hbus_pkg::P_WRITE_CMD;
  assign hbus_rrq_o = state_q == hbus_pkg::P_READ_CMD;
  assign hbus_adr_o = hbus_pkg::hbus_addr_t'(adr_q >> 1);
  assign hbus_dat_o = beat_q ? wdata_q[31:16] : wdata_q[15:0];

  assign dn_req.credit = state_q == hbus_pkg::P_DONE;
  assign rsp_valid_o   = (state_q == hbus_pkg::P_DONE) && !we_q;
  assign rsp_data_o    = rdata_q;

  always_ff @(posedge wb_clk) begin
    if (wb_rst) begin
      state_q <= hbus_pkg::P_IDLE;
      pend_q  <= 1'b0;
      beat_q  <= 1'b0;
    end else begin
      case (state_q)
        hbus_pkg::P_IDLE: begin
          if (dn_req.req_valid) begin
            pend_q <= 1'b1;
          end else if (pend_q && !hbus_busy_i) begin
            pend_q  <= 1'b0;
            state_q <= we_q ? hbus_pkg::P_WRITE_CMD : hbus_pkg::P_READ_CMD;
          end
        end
        hbus_pkg::P_WRITE_CMD: begin
          if (hbus_ready_i) begin
            beat_q  <= 1'b0;
            state_q <= hbus_pkg::P_WRITE_DATA;
          end
        end
        hbus_pkg::P_WRITE_DATA: begin
          if (hbus_ready_i) begin
            beat_q <= 1'b1;
            if (beat_q) begin
              state_q <= hbus_pkg::P_DONE;
            end
          end
        end
        hbus_pkg::P_READ_CMD: begin
          if (hbus_ready_i) begin
            beat_q  <= 1'b0;
            state_q <= hbus_pkg::P_READ_DATA;
          end
        end
        hbus_pkg::P_READ_DATA: begin
          if (hbus_valid_i) begin
            beat_q <= 1'b1;
            if (beat_q) begin
              state_q <= hbus_pkg::P_DONE;
            end
          end
        end
        default: begin
          beat_q  <= 1'b0;
          state_q <= hbus_pkg::P_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge wb_clk) begin
    if (state_q == hbus_pkg::P_IDLE && dn_req.req_valid) begin
      we_q    <= dn_req.req_we;
      adr_q   <= dn_req.req_adr;
      wdata_q <= dn_req.req_wdata;
    end
    if (state_q == hbus_pkg::P_READ_DATA && hbus_valid_i) begin
      if (beat_q) begin
        rdata_q[31:16] <= hbus_dat_i;
      end else begin
        rdata_q[15:0] <= hbus_dat_i;
      end
    end
  end

endmodule

/* rtl/hbus_pkg.sv */
package hbus_pkg;

  typedef logic [31:0] wb_addr_t;   // byte address
  typedef logic [31:0] wb_data_t;
  typedef logic [31:0] hbus_addr_t; // half-word address
  typedef logic [15:0] hbus_data_t; // one beat

  // both enums share one scope, so literals carry a prefix
  typedef enum logic [1:0] {
    S_IDLE,
    S_READ_WAIT,
    S_ACK
  } slave_state_e;

  typedef enum logic [2:0] {
    P_IDLE,
    P_WRITE_CMD,
    P_WRITE_DATA,
    P_READ_CMD,
    P_READ_DATA,
    P_DONE
  } phy_state_e;

endpackage

/* rtl/hbus_req_fifo.sv */
`timescale 1ns/100ps

module hbus_req_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic       wb_clk,
  input  logic       wb_rst,
  hbus_req_if.slave  up_req,
  hbus_req_if.master dn_req
);

  localparam int PTR_W      = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);
  localparam int DN_CREDITS = 1; // the phy holds a single request

  logic               we_mem    [FIFO_DEPTH];
  hbus_pkg::wb_addr_t adr_mem   [FIFO_DEPTH];
  hbus_pkg::wb_data_t wdata_mem [FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [CNT_W-1:0]   count_q;
  logic [1:0]         dn_credit_q;
  logic               push;
  logic               pop;

  assign push = up_req.req_valid;
  assign pop  = (count_q != '0) && (dn_credit_q != '0);

  assign dn_req.req_valid = pop;
  assign dn_req.req_we    = we_mem[rd_ptr_q];
  assign dn_req.req_adr   = adr_mem[rd_ptr_q];
  assign dn_req.req_wdata = wdata_mem[rd_ptr_q];
  assign up_req.credit    = pop; // slot is free once the head leaves

  always_ff @(posedge wb_clk) begin
    if (push) begin
      we_mem[wr_ptr_q]    <= up_req.req_we;
      adr_mem[wr_ptr_q]   <= up_req.req_adr;
      wdata_mem[wr_ptr_q] <= up_req.req_wdata;
    end
  end

  always_ff @(posedge wb_clk) begin
    if (wb_rst) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      dn_credit_q <= 2'(DN_CREDITS);
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q     <= count_q + CNT_W'(push) - CNT_W'(pop);
      dn_credit_q <= dn_credit_q + 2'(dn_req.credit) - 2'(pop);
    end
  end

endmodule

/* rtl/hbus_req_if.sv */
`timescale 1ns/100ps

interface hbus_req_if;

  logic               req_valid; // one-cycle pulse, spends a credit
  logic               req_we;
  hbus_pkg::wb_addr_t req_adr;
  hbus_pkg::wb_data_t req_wdata;
  logic               credit;    // one-cycle pulse, slot freed

  modport master (
    output req_valid,
    output req_we,
    output req_adr,
    output req_wdata,
    input  credit
  );

  modport slave (
    input  req_valid,
    input  req_we,
    input  req_adr,
    input  req_wdata,
    output credit
  );

endinterface

/* rtl/hbus_wishbone.sv */
`timescale 1ns/100ps

module hbus_wishbone #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                 wb_clk,
  input  logic                 wb_rst,
  input  hbus_pkg::wb_addr_t   wb_adr_i,
  input  hbus_pkg::wb_data_t   wb_dat_i,
  input  logic                 wb_we_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  output hbus_pkg::wb_data_t   wb_dat_o,
  output logic                 wb_ack_o,
  output logic                 wb_err_o,
  output logic                 wb_rty_o,
  output hbus_pkg::hbus_addr_t hbus_adr_o,
  input  hbus_pkg::hbus_data_t hbus_dat_i,
  output hbus_pkg::hbus_data_t hbus_dat_o,
  output logic                 hbus_rrq_o,
  output logic                 hbus_wrq_o,
  input  logic                 hbus_ready_i,
  input  logic                 hbus_valid_i,
  input  logic                 hbus_busy_i
);

  logic               rsp_valid; // read done, one cycle
  hbus_pkg::wb_data_t rsp_data;

  hbus_req_if up_req ();
  hbus_req_if dn_req ();

  wb_hbus_slave #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_wb_hbus_slave (
    .wb_clk      (wb_clk),
    .wb_rst      (wb_rst),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_we_i     (wb_we_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .wb_err_o    (wb_err_o),
    .wb_rty_o    (wb_rty_o),
    .rsp_valid_i (rsp_valid),
    .rsp_data_i  (rsp_data),
    .up_req      (up_req.master)
  );

  hbus_req_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_hbus_req_fifo (
    .wb_clk (wb_clk),
    .wb_rst (wb_rst),
    .up_req (up_req.slave),
    .dn_req (dn_req.master)
  );

  hbus_phy_ctrl i_hbus_phy_ctrl (
    .wb_clk       (wb_clk),
    .wb_rst       (wb_rst),
    .hbus_adr_o   (hbus_adr_o),
    .hbus_dat_i   (hbus_dat_i),
    .hbus_dat_o   (hbus_dat_o),
    .hbus_rrq_o   (hbus_rrq_o),
    .hbus_wrq_o   (hbus_wrq_o),
    .hbus_ready_i (hbus_ready_i),
    .hbus_valid_i (hbus_valid_i),
    .hbus_busy_i  (hbus_busy_i),
    .rsp_valid_o  (rsp_valid),
    .rsp_data_o   (rsp_data),
    .dn_req       (dn_req.slave)
  );

endmodule

/* rtl/wb_hbus_slave.sv */
`timescale 1ns/100ps

module wb_hbus_slave #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic               wb_clk,
  input  logic               wb_rst,
  input  hbus_pkg::wb_addr_t wb_adr_i,
  input  hbus_pkg::wb_data_t wb_dat_i,
  input  logic               wb_we_i,
  input  logic               wb_cyc_i,
  input  logic               wb_stb_i,
  output hbus_pkg::wb_data_t wb_dat_o,
  output logic               wb_ack_o,
  output logic               wb_err_o,
  output logic               wb_rty_o,
  input  logic               rsp_valid_i,
  input  hbus_pkg::wb_data_t rsp_data_i,
  hbus_req_if.master         up_req
);

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  hbus_pkg::slave_state_e state_q;
  logic [CNT_W-1:0]       credit_q;
  logic                   req_valid_q;
  logic                   req_we_q;
  hbus_pkg::wb_addr_t     req_adr_q;
  hbus_pkg::wb_data_t     req_wdata_q;
  logic                   strobe;
  logic                   misaligned;
  logic                   has_credit;
  logic                   issue;

  assign strobe     = wb_cyc_i & wb_stb_i;
  assign misaligned = wb_adr_i[1:0] != 2'b00;
  assign has_credit = credit_q != '0;
  assign issue      = (state_q == hbus_pkg::S_IDLE) && strobe && !misaligned && has_credit;

  assign up_req.req_valid = req_valid_q;
  assign up_req.req_we    = req_we_q;
  assign up_req.req_adr   = req_adr_q;
  assign up_req.req_wdata = req_wdata_q;

  // credit is spent in the cycle the request pulse goes out
  always_ff @(posedge wb_clk) begin
    if (wb_rst) begin
      credit_q <= CNT_W'(FIFO_DEPTH);
    end else begin
      credit_q <= credit_q + CNT_W'(up_req.credit) - CNT_W'(req_valid_q);
    end
  end

  always_ff @(posedge wb_clk) begin
    if (wb_rst) begin
      state_q     <= hbus_pkg::S_IDLE;
      req_valid_q <= 1'b0;
      wb_ack_o    <= 1'b0;
      wb_err_o    <= 1'b0;
      wb_rty_o    <= 1'b0;
    end else begin
      req_valid_q <= issue;
      case (state_q)
        hbus_pkg::S_IDLE: begin
          if (strobe) begin
            if (misaligned) begin
              wb_err_o <= 1'b1; // no request goes out
              state_q  <= hbus_pkg::S_ACK;
            end else if (!has_credit) begin
              wb_rty_o <= 1'b1;
              state_q  <= hbus_pkg::S_ACK;
            end else if (wb_we_i) begin
              wb_ack_o <= 1'b1; // posted write
              state_q  <= hbus_pkg::S_ACK;
            end else begin
              state_q  <= hbus_pkg::S_READ_WAIT;
            end
          end
        end
        hbus_pkg::S_READ_WAIT: begin
          if (rsp_valid_i) begin
            wb_ack_o <= 1'b1;
            state_q  <= hbus_pkg::S_ACK;
          end
        end
        default: begin
          // the strobe is still up while the answer is out
          wb_ack_o <= 1'b0;
          wb_err_o <= 1'b0;
          wb_rty_o <= 1'b0;
          state_q  <= hbus_pkg::S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge wb_clk) begin
    if (issue) begin
      req_we_q    <= wb_we_i;
      req_adr_q   <= wb_adr_i;
      req_wdata_q <= wb_dat_i;
    end
    if (state_q == hbus_pkg::S_READ_WAIT && rsp_valid_i) begin
      wb_dat_o <= rsp_data_i;
    end
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the Wishbone to HyperBus bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_hbus_wishbone \
  -f sources.f \
  --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log || ! grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

/* sources.f */
rtl/hbus_pkg.sv
rtl/hbus_req_if.sv
rtl/wb_hbus_slave.sv
rtl/hbus_req_fifo.sv
rtl/hbus_phy_ctrl.sv
rtl/hbus_wishbone.sv
test/hbus_device_model.sv
test/hbus_wishbone_props.sv
test/tb_hbus_wishbone.sv

/* test/hbus_device_model.sv */
`timescale 1ns/100ps

module hbus_device_model (
  input  logic                 wb_clk,
  input  logic                 wb_rst,
  input  hbus_pkg::hbus_addr_t hbus_adr_i,
  input  hbus_pkg::hbus_data_t hbus_dat_i,
  input  logic                 hbus_wrq_i,
  input  logic                 hbus_rrq_i,
  output logic                 hbus_ready_o,
  output logic                 hbus_valid_o,
  output hbus_pkg::hbus_data_t hbus_dat_o
);

  typedef enum logic [1:0] {M_IDLE, M_CMD, M_WDATA, M_RDATA} model_state_e;

  hbus_pkg::hbus_data_t mem [256]; // half-word memory
  model_state_e         state;
  logic                 is_write;
  logic                 beat;
  logic [7:0]           base;

  initial begin
    hbus_ready_o = 1'b0;
    hbus_valid_o = 1'b0;
    hbus_dat_o   = '0;
  end

  always @(posedge wb_clk) begin : model_fsm
    int i;
    if (wb_rst) begin
      state        <= M_IDLE;
      hbus_ready_o <= 1'b0;
      hbus_valid_o <= 1'b0;
      beat         <= 1'b0;
      for (i = 0; i < 256; i++) begin
        mem[i] <= {~8'(i), 8'(i)}; // fill follows the full index
      end
    end else begin
      case (state)
        M_IDLE: begin
          if (hbus_wrq_i || hbus_rrq_i) begin
            hbus_ready_o <= 1'b1; // grant one cycle into the command
            is_write     <= hbus_wrq_i;
            base         <= hbus_adr_i[7:0];
            state        <= M_CMD;
          end
        end
        M_CMD: begin
          hbus_ready_o <= 1'b0;
          beat         <= 1'b0;
          state        <= is_write ? M_WDATA : M_RDATA;
        end
        M_WDATA: begin
          hbus_ready_o <= !hbus_ready_o;
          if (hbus_ready_o) begin
            mem[base + 8'(beat)] <= hbus_dat_i;
            beat                 <= 1'b1;
            if (beat) begin
              state <= M_IDLE;
            end
          end
        end
        default: begin
          hbus_valid_o <= !hbus_valid_o;
          if (!hbus_valid_o) begin
            hbus_dat_o <= mem[base + 8'(beat)]; // low half first
          end else begin
            beat <= 1'b1;
            if (beat) begin
              state <= M_IDLE;
            end
          end
        end
      endcase
    end
  end

endmodule

/* test/hbus_wishbone_props.sv */
`timescale 1ns/100ps

module hbus_wishbone_props (
  input logic                 wb_clk,
  input logic                 wb_rst,
  input logic                 wb_ack_o,
  input logic                 wb_err_o,
  input logic                 wb_rty_o,
  input hbus_pkg::hbus_addr_t hbus_adr_o,
  input logic                 hbus_rrq_o,
  input logic                 hbus_wrq_o,
  input logic                 hbus_ready_i
);

  no_dual_cmd: assert property (@(posedge wb_clk) disable iff (wb_rst)
    !(hbus_wrq_o && hbus_rrq_o))
    else $error("write and read command high together");

  one_answer: assert property (@(posedge wb_clk) disable iff (wb_rst)
    $onehot0({wb_ack_o, wb_err_o, wb_rty_o}))
    else $error("more than one of ack, err and rty high");

  adr_held: assert property (@(posedge wb_clk) disable iff (wb_rst)
    (hbus_wrq_o || hbus_rrq_o) && !hbus_ready_i |=> $stable(hbus_adr_o))
    else $error("command address changed before ready");

  ack_pulse: assert property (@(posedge wb_clk) disable iff (wb_rst)
    wb_ack_o |=> !wb_ack_o)
    else $error("ack high for more than one cycle");

  err_pulse: assert property (@(posedge wb_clk) disable iff (wb_rst)
    wb_err_o |=> !wb_err_o)
    else $error("err high for more than one cycle");

  rty_pulse: assert property (@(posedge wb_clk) disable iff (wb_rst)
    wb_rty_o |=> !wb_rty_o)
    else $error("rty high for more than one cycle");

endmodule

bind hbus_wishbone hbus_wishbone_props i_hbus_wishbone_props (
  .wb_clk       (wb_clk),
  .wb_rst       (wb_rst),
  .wb_ack_o     (wb_ack_o),
  .wb_err_o     (wb_err_o),
  .wb_rty_o     (wb_rty_o),
  .hbus_adr_o   (hbus_adr_o),
  .hbus_rrq_o   (hbus_rrq_o),
  .hbus_wrq_o   (hbus_wrq_o),
  .hbus_ready_i (hbus_ready_i)
);

/* test/tb_hbus_wishbone.sv */
`timescale 1ns/100ps

module tb_hbus_wishbone;

  localparam int FIFO_DEPTH = 4;
  localparam int TIMEOUT    = 100; // cycles per response
  localparam int MAX_TRIES  = 20;
  localparam int ERR_WINDOW = 12;  // cycles watched after an err

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_BUSY_ON, OP_BUSY_OFF} op_e;
  typedef enum logic [1:0] {K_NONE, K_ACK, K_ERR, K_RTY} kind_e;
  typedef struct packed {
    op_e                op;
    hbus_pkg::wb_addr_t adr;
    hbus_pkg::wb_data_t wdata;
    kind_e              kind;
    hbus_pkg::wb_data_t rdata; // expected read data
  } entry_t;

  logic                 wb_clk = 1'b0;
  logic                 wb_rst;
  hbus_pkg::wb_addr_t   wb_adr_i;
  hbus_pkg::wb_data_t   wb_dat_i;
  logic                 wb_we_i;
  logic                 wb_cyc_i;
  logic                 wb_stb_i;
  hbus_pkg::wb_data_t   wb_dat_o;
  logic                 wb_ack_o;
  logic                 wb_err_o;
  logic                 wb_rty_o;
  hbus_pkg::hbus_addr_t hbus_adr_o;
  hbus_pkg::hbus_data_t hbus_dat_i;
  hbus_pkg::hbus_data_t hbus_dat_o;
  logic                 hbus_rrq_o;
  logic                 hbus_wrq_o;
  logic                 hbus_ready_i;
  logic                 hbus_valid_i;
  logic                 hbus_busy_i;

  entry_t             stim [$];
  hbus_pkg::wb_data_t shadow [128];
  logic [31:0]        rng_state;
  int                 passes;
  int                 failures;
  int                 cmd_cycles = 0;
  logic               timed_out;
  int                 i;

  hbus_wishbone #(.FIFO_DEPTH(FIFO_DEPTH)) i_hbus_wishbone (.*);

  hbus_device_model i_hbus_device_model (
    .wb_clk       (wb_clk),
    .wb_rst       (wb_rst),
    .hbus_adr_i   (hbus_adr_o),
    .hbus_dat_i   (hbus_dat_o),
    .hbus_wrq_i   (hbus_wrq_o),
    .hbus_rrq_i   (hbus_rrq_o),
    .hbus_ready_o (hbus_ready_i),
    .hbus_valid_o (hbus_valid_i),
    .hbus_dat_o   (hbus_dat_i)
  );

  always #50 wb_clk = ~wb_clk;

  always @(negedge wb_clk) begin
    if (hbus_wrq_o || hbus_rrq_o) begin
      cmd_cycles <= cmd_cycles + 1; // command activity on the device port
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // word as seen in the device, high half at the next half-word
  function automatic hbus_pkg::wb_data_t mem_word(input hbus_pkg::wb_addr_t adr);
    logic [7:0] idx;
    idx = 8'(adr >> 1);
    return {i_hbus_device_model.mem[idx + 8'd1], i_hbus_device_model.mem[idx]};
  endfunction

  task automatic check(input logic ok, input string what);
    assert (ok) begin
      passes++;
    end else begin
      $display("FAIL %0t: %s", $time, what);
      failures++;
    end
  endtask

  task automatic add_entry(input op_e op, input hbus_pkg::wb_addr_t adr, input kind_e kind);
    entry_t e;
    e.op    = op;
    e.adr   = adr;
    e.kind  = kind;
    e.wdata = '0;
    e.rdata = '0;
    if (op == OP_WR) begin
      rng_state = xorshift32(rng_state);
      e.wdata   = rng_state;
      if (kind == K_ACK) begin
        shadow[adr[8:2]] = rng_state;
      end
    end else if (op == OP_RD && kind == K_ACK) begin
      e.rdata = shadow[adr[8:2]];
    end
    stim.push_back(e);
  endtask

  task automatic build_stimulus();
    int k;
    add_entry(OP_WR, 32'h010, K_ACK);
    add_entry(OP_RD, 32'h010, K_ACK);
    add_entry(OP_WR, 32'h020, K_ACK);
    add_entry(OP_WR, 32'h024, K_ACK);
    add_entry(OP_WR, 32'h040, K_ACK);
    add_entry(OP_WR, 32'h06c, K_ACK);
    add_entry(OP_WR, 32'h100, K_ACK);
    add_entry(OP_RD, 32'h100, K_ACK); // read back in another order
    add_entry(OP_RD, 32'h024, K_ACK);
    add_entry(OP_RD, 32'h06c, K_ACK);
    add_entry(OP_RD, 32'h020, K_ACK);
    add_entry(OP_RD, 32'h040, K_ACK);
    add_entry(OP_WR, 32'h022, K_ERR);
    add_entry(OP_RD, 32'h041, K_ERR);
    add_entry(OP_WR, 32'h013, K_ERR);
    add_entry(OP_BUSY_ON, '0, K_NONE);
    // queue slots plus the request parked in the phy
    for (k = 0; k <= FIFO_DEPTH; k++) begin
      add_entry(OP_WR, 32'h140 + 32'(4 * k), K_ACK);
    end
    add_entry(OP_WR, 32'h140 + 32'(4 * (FIFO_DEPTH + 1)), K_RTY);
    add_entry(OP_BUSY_OFF, '0, K_NONE);
    for (k = 0; k <= FIFO_DEPTH; k++) begin
      add_entry(OP_RD, 32'h140 + 32'(4 * k), K_ACK);
    end
    add_entry(OP_RD, 32'h010, K_ACK);
  endtask

  // one Wishbone cycle, repeated on rty when allowed
  task automatic run_cycle(input logic we, input hbus_pkg::wb_addr_t adr,
                           input hbus_pkg::wb_data_t wdata, input logic allow_retry,
                           output kind_e got, output hbus_pkg::wb_data_t rdata);
    int   waited;
    int   tries;
    logic done;
    tries = 0;
    done  = 1'b0;
    rdata = '0;
    got   = K_NONE;
    while (!done) begin
      @(posedge wb_clk);
      wb_cyc_i <= 1'b1;
      wb_stb_i <= 1'b1;
      wb_we_i  <= we;
      wb_adr_i <= adr;
      wb_dat_i <= we ? wdata : '0;
      waited = 0;
      got    = K_NONE;
      while (got == K_NONE && waited < TIMEOUT) begin
        @(negedge wb_clk);
        waited++;
        if (wb_ack_o) begin
          got   = K_ACK;
          rdata = wb_dat_o;
        end else if (wb_err_o) begin
          got = K_ERR;
        end else if (wb_rty_o) begin
          got = K_RTY;
        end
      end
      @(posedge wb_clk);
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      tries++;
      if (got == K_NONE) begin
        $display("timeout: no ack, err or rty within %0d cycles at adr %h", TIMEOUT, adr);
        timed_out = 1'b1;
      end
      done = got != K_RTY || !allow_retry || tries >= MAX_TRIES;
    end
  endtask

  task automatic apply_entry(input int idx);
    entry_t             e;
    kind_e              got;
    hbus_pkg::wb_data_t rdata;
    hbus_pkg::wb_data_t mem_before;
    int                 cmd_before;
    int                 fails_before;
    e            = stim[idx];
    fails_before = failures;
    if (e.op == OP_BUSY_ON || e.op == OP_BUSY_OFF) begin
      @(posedge wb_clk);
      hbus_busy_i <= e.op == OP_BUSY_ON;
    end else begin
      mem_before = mem_word(e.adr);
      cmd_before = cmd_cycles;
      run_cycle(e.op == OP_WR, e.adr, e.wdata, e.kind != K_RTY, got, rdata);
      if (!timed_out) begin
        check(got == e.kind, $sformatf("entry %0d response %s, expected %s",
                                       idx, got.name(), e.kind.name()));
        if (e.op == OP_RD && e.kind == K_ACK) begin
          check(rdata == e.rdata, $sformatf("entry %0d read %h, expected %h",
                                            idx, rdata, e.rdata));
          check(mem_word(e.adr) == e.rdata, $sformatf("entry %0d device holds %h, expected %h",
                                                      idx, mem_word(e.adr), e.rdata));
        end
        if (e.kind == K_ERR) begin
          // a request that slipped through would reach the device in this window
          repeat (ERR_WINDOW) @(negedge wb_clk);
          check(cmd_cycles == cmd_before, $sformatf("entry %0d reached the device", idx));
          check(mem_word(e.adr) == mem_before, $sformatf("entry %0d changed memory", idx));
        end
      end
    end
    $display("entry %0d %s adr=%h: %s", idx, e.op.name(), e.adr,
             (failures == fails_before && !timed_out) ? "ok" : "bad");
  endtask

  initial begin
    wb_rst      = 1'b1;
    wb_adr_i    = '0;
    wb_dat_i    = '0;
    wb_we_i     = 1'b0;
    wb_cyc_i    = 1'b0;
    wb_stb_i    = 1'b0;
    hbus_busy_i = 1'b0;
    passes      = 0;
    failures    = 0;
    timed_out   = 1'b0;
    rng_state   = 32'heeb76855;
    build_stimulus();
    repeat (3) @(posedge wb_clk);
    wb_rst <= 1'b0;
    for (i = 0; i < stim.size() && !timed_out; i++) begin
      apply_entry(i);
    end
    $display("checks: %0d passed, %0d failed", passes, failures);
    if (failures == 0 && !timed_out) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
